// ==== Makefile ====
TOP := tb_soc_harness

.PHONY: all run clean

all: run

obj_dir/V$(TOP): soc_harness.f harness_settings.svh $(shell grep -v '^+' soc_harness.f)
	verilator --binary --timing --assert -Wno-fatal -f soc_harness.f \
		--top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== harness_settings.svh ====
/*
  soc harness settings
  widths, the debug hold-off window, the error counter width and the
  base and length of every region in the peripheral map
*/
`ifndef HARNESS_SETTINGS_SVH
`define HARNESS_SETTINGS_SVH

`define HARNESS_ADDR_WIDTH      64
`define HARNESS_XLEN            64
`define HARNESS_DMI_ADDR_WIDTH  7
`define HARNESS_DMI_DATA_WIDTH  32
`define HARNESS_DMI_DEL_CYCLES  64
`define HARNESS_ERR_CNT_WIDTH   16
`define HARNESS_NUM_PERIPH      11

// peripheral map, bases and lengths in bytes
`define HARNESS_DEBUG_BASE  64'h0000_0000
`define HARNESS_DEBUG_LEN   64'h0000_1000
`define HARNESS_ROM_BASE    64'h0001_0000
`define HARNESS_ROM_LEN     64'h0001_0000
`define HARNESS_CLINT_BASE  64'h0200_0000
`define HARNESS_CLINT_LEN   64'h000C_0000
`define HARNESS_PLIC_BASE   64'h0C00_0000
`define HARNESS_PLIC_LEN    64'h0400_0000
`define HARNESS_UART_BASE   64'h1000_0000
`define HARNESS_UART_LEN    64'h0000_1000
`define HARNESS_TIMER_BASE  64'h1800_0000
`define HARNESS_TIMER_LEN   64'h0000_1000
`define HARNESS_SPI_BASE    64'h2000_0000
`define HARNESS_SPI_LEN     64'h0080_0000
`define HARNESS_ETH_BASE    64'h3000_0000
`define HARNESS_ETH_LEN     64'h0001_0000
`define HARNESS_GPIO_BASE   64'h4000_0000
`define HARNESS_GPIO_LEN    64'h0000_1000
`define HARNESS_CLIC_BASE   64'h5000_0000
`define HARNESS_CLIC_LEN    64'h0001_0000
`define HARNESS_DRAM_BASE   64'h8000_0000
`define HARNESS_DRAM_LEN    64'h4000_0000

`endif

// ==== logic/access_error_counter.sv ====
/*
  access_error_counter
  saturating counts of unmapped reads and unmapped writes
*/
`timescale 1ns/1ps
`default_nettype none

module access_error_counter import harness_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clr_i,
  periph_sel_if.dst sel,
  output err_cnt_t  rd_err_cnt_o,
  output err_cnt_t  wr_err_cnt_o
);

  err_cnt_t rd_cnt_q;
  err_cnt_t wr_cnt_q;
  logic     err_hit;

  assign err_hit = sel.valid & sel.decerr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else if (clr_i) begin
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
    end else if (err_hit) begin
      // stick at all ones
      if (sel.write && wr_cnt_q != '1) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end else if (!sel.write && rd_cnt_q != '1) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
    end
  end

  assign rd_err_cnt_o = rd_cnt_q;
  assign wr_err_cnt_o = wr_cnt_q;

endmodule

`default_nettype wire

// ==== logic/addr_region_decode.sv ====
/*
  addr_region_decode
  looks a bus address up in the peripheral map, all entries compared in
  parallel; index, write flag and decode error come out one cycle later
*/
`timescale 1ns/1ps
`default_nettype none

`include "harness_settings.svh"

module addr_region_decode import harness_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic             we_i,
  input  addr_t            addr_i,
  periph_sel_if.src        sel
);

  localparam int unsigned NumPeriph = `HARNESS_NUM_PERIPH;

  // ------------------------------------------------------------------------
  // peripheral map, entry order follows periph_idx_e
  // ------------------------------------------------------------------------
  localparam addr_t RegionBase [NumPeriph] = '{
    `HARNESS_DEBUG_BASE, `HARNESS_ROM_BASE, `HARNESS_CLINT_BASE, `HARNESS_PLIC_BASE,
    `HARNESS_UART_BASE, `HARNESS_TIMER_BASE, `HARNESS_SPI_BASE, `HARNESS_ETH_BASE,
    `HARNESS_GPIO_BASE, `HARNESS_DRAM_BASE, `HARNESS_CLIC_BASE
  };
  localparam addr_t RegionLen [NumPeriph] = '{
    `HARNESS_DEBUG_LEN, `HARNESS_ROM_LEN, `HARNESS_CLINT_LEN, `HARNESS_PLIC_LEN,
    `HARNESS_UART_LEN, `HARNESS_TIMER_LEN, `HARNESS_SPI_LEN, `HARNESS_ETH_LEN,
    `HARNESS_GPIO_LEN, `HARNESS_DRAM_LEN, `HARNESS_CLIC_LEN
  };

  periph_idx_e hit_idx;
  logic        hit;
  logic        valid_q;
  logic        decerr_q;
  logic        write_q;
  periph_idx_e idx_q;

  // regions do not overlap, so at most one entry hits
  always_comb begin
    hit_idx = PERIPH_DEBUG;
    hit     = 1'b0;
    for (int i = 0; i < NumPeriph; i++) begin
      if (addr_i >= RegionBase[i] && addr_i < RegionBase[i] + RegionLen[i]) begin
        hit     = 1'b1;
        hit_idx = periph_idx_e'(4'(i));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      decerr_q <= 1'b0;
    end else begin
      valid_q  <= req_i;
      decerr_q <= req_i & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      write_q <= we_i;
      idx_q   <= hit_idx;
    end
  end

  assign sel.valid  = valid_q;
  assign sel.decerr = decerr_q;
  assign sel.write  = write_q;
  assign sel.idx    = idx_q;

  a_decerr_idx : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (sel.valid && sel.decerr) |-> (sel.idx == PERIPH_DEBUG)
  );

endmodule

`default_nettype wire

// ==== logic/debug_req_gate.sv ====
/*
  debug_req_gate
  holds the core halt request off for a fixed window after reset so
  boot code runs first, and masks it when debug is disabled
*/
`timescale 1ns/1ps
`default_nettype none

`include "harness_settings.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_en_i,
  input  logic halt_req_i,
  output logic halt_req_o
);

  localparam int unsigned CntWidth = $clog2(`HARNESS_DMI_DEL_CYCLES + 1);

  logic [CntWidth-1:0] del_cnt_q;
  logic                del_done;

  assign del_done   = (del_cnt_q == '0);
  assign halt_req_o = del_done & debug_en_i & halt_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntWidth'(`HARNESS_DMI_DEL_CYCLES);
    end else if (!del_done) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  // a halt only lands once the whole window has passed since reset
  a_no_halt_in_window : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    halt_req_o |-> $past(rst_ni, `HARNESS_DMI_DEL_CYCLES)
  );

endmodule

`default_nettype wire

// ==== logic/dmi_source_mux.sv ====
/*
  dmi_source_mux
  shares the debug module port between a JTAG and a DTM request source;
  the select only moves while no transaction is in flight
*/
`timescale 1ns/1ps
`default_nettype none

module dmi_source_mux import harness_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      jtag_sel_i,
  input  dmi_req_t  jtag_req_i,
  input  logic      jtag_req_valid_i,
  output logic      jtag_req_ready_o,
  output dmi_resp_t jtag_resp_o,
  output logic      jtag_resp_valid_o,
  input  logic      jtag_resp_ready_i,
  input  dmi_req_t  dtm_req_i,
  input  logic      dtm_req_valid_i,
  output logic      dtm_req_ready_o,
  output dmi_resp_t dtm_resp_o,
  output logic      dtm_resp_valid_o,
  input  logic      dtm_resp_ready_i,
  output dmi_req_t  dm_req_o,
  output logic      dm_req_valid_o,
  input  logic      dm_req_ready_i,
  input  dmi_resp_t dm_resp_i,
  input  logic      dm_resp_valid_i,
  output logic      dm_resp_ready_o
);

  logic jtag_sel_q;
  logic outstanding_q;
  logic req_fire;
  logic resp_fire;

  // request path towards the debug module
  assign dm_req_o        = jtag_sel_q ? jtag_req_i        : dtm_req_i;
  assign dm_req_valid_o  = jtag_sel_q ? jtag_req_valid_i  : dtm_req_valid_i;
  assign dm_resp_ready_o = jtag_sel_q ? jtag_resp_ready_i : dtm_resp_ready_i;

  // unselected side sees a stalled port
  assign jtag_req_ready_o  = jtag_sel_q & dm_req_ready_i;
  assign dtm_req_ready_o   = ~jtag_sel_q & dm_req_ready_i;
  assign jtag_resp_valid_o = jtag_sel_q & dm_resp_valid_i;
  assign dtm_resp_valid_o  = ~jtag_sel_q & dm_resp_valid_i;
  assign jtag_resp_o       = dm_resp_i;
  assign dtm_resp_o        = dm_resp_i;

  assign req_fire  = dm_req_valid_o & dm_req_ready_i;
  assign resp_fire = dm_resp_valid_i & dm_resp_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      jtag_sel_q    <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      // a request accepted this cycle already pins the select
      if (!outstanding_q && !req_fire) begin
        jtag_sel_q <= jtag_sel_i;
      end
      if (req_fire) begin
        outstanding_q <= 1'b1;
      end else if (resp_fire) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // the debug module only answers requests it has taken
  a_resp_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) dm_resp_valid_i |-> outstanding_q
  );

endmodule

`default_nettype wire

// ==== logic/harness_pkg.sv ====
/*
  harness_pkg
  shared types of the soc harness: debug transport request and
  response, peripheral index, bus address, interrupt vector and id,
  error count
*/
`default_nettype none

`include "harness_settings.svh"

package harness_pkg;

  typedef logic [`HARNESS_ADDR_WIDTH-1:0] addr_t;

  // debug transport
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef struct packed {
    logic [`HARNESS_DMI_ADDR_WIDTH-1:0] addr;
    dtm_op_e                            op;
    logic [`HARNESS_DMI_DATA_WIDTH-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [`HARNESS_DMI_DATA_WIDTH-1:0] data;
    logic [1:0]                         resp;
  } dmi_resp_t;

  // map order, index 0 doubles as the decode error index
  typedef enum logic [3:0] {
    PERIPH_DEBUG, PERIPH_ROM, PERIPH_CLINT, PERIPH_PLIC, PERIPH_UART, PERIPH_TIMER,
    PERIPH_SPI, PERIPH_ETH, PERIPH_GPIO, PERIPH_DRAM, PERIPH_CLIC
  } periph_idx_e;

  typedef logic [`HARNESS_XLEN-1:0]          irq_vec_t;
  typedef logic [$clog2(`HARNESS_XLEN)-1:0]  irq_id_t;
  typedef logic [`HARNESS_ERR_CNT_WIDTH-1:0] err_cnt_t;

endpackage

`default_nettype wire

// ==== logic/irq_route.sv ====
/*
  irq_route
  places meip, seip and mtip at their privileged-spec positions and
  hands the highest pending one to the core as id plus one-hot word,
  held until the core acknowledges
*/
`timescale 1ns/1ps
`default_nettype none

module irq_route import harness_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     meip_i,
  input  logic     seip_i,
  input  logic     mtip_i,
  input  logic     irq_ack_i,
  output irq_vec_t irq_vec_o,
  output logic     irq_valid_o,
  output irq_id_t  irq_id_o,
  output irq_vec_t irq_onehot_o
);

  localparam int unsigned MeipBit = 11;
  localparam int unsigned SeipBit = 9;
  localparam int unsigned MtipBit = 7;

  irq_vec_t irq_vec;
  irq_id_t  pend_id;
  logic     valid_q;
  irq_id_t  id_q;

  // everything else is reserved or platform use
  always_comb begin
    irq_vec          = '0;
    irq_vec[MeipBit] = meip_i;
    irq_vec[SeipBit] = seip_i;
    irq_vec[MtipBit] = mtip_i;
  end

  // highest index wins
  always_comb begin
    pend_id = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (irq_vec[i]) begin
        pend_id = irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      valid_q <= ~irq_ack_i;
    end else begin
      valid_q <= |irq_vec;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!valid_q) begin
      id_q <= pend_id;
    end
  end

  always_comb begin
    irq_onehot_o = '0;
    if (valid_q) begin
      irq_onehot_o[id_q] = 1'b1;
    end
  end

  assign irq_vec_o   = irq_vec;
  assign irq_valid_o = valid_q;
  assign irq_id_o    = id_q;

  a_id_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_q && !irq_ack_i) |=> (valid_q && $stable(id_q))
  );

endmodule

`default_nettype wire

// ==== logic/periph_sel_if.sv ====
/*
  periph_sel_if
  registered result of an address decode, one strobe per access
*/
`timescale 1ns/1ps
`default_nettype none

interface periph_sel_if import harness_pkg::*; ();
  logic        valid;
  logic        write;
  periph_idx_e idx;
  logic        decerr;

  modport src (output valid, output write, output idx, output decerr);
  modport dst (input valid, input write, input idx, input decerr);
endinterface

`default_nettype wire

// ==== logic/soc_harness_top.sv ====
/*
  soc_harness_top
  harness glue: debug transport mux, halt request gate, address decode
  with error counters and local interrupt routing
*/
`timescale 1ns/1ps
`default_nettype none

module soc_harness_top import harness_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // debug transport
  input  logic        jtag_sel_i,
  input  dmi_req_t    jtag_req_i,
  input  logic        jtag_req_valid_i,
  output logic        jtag_req_ready_o,
  output dmi_resp_t   jtag_resp_o,
  output logic        jtag_resp_valid_o,
  input  logic        jtag_resp_ready_i,
  input  dmi_req_t    dtm_req_i,
  input  logic        dtm_req_valid_i,
  output logic        dtm_req_ready_o,
  output dmi_resp_t   dtm_resp_o,
  output logic        dtm_resp_valid_o,
  input  logic        dtm_resp_ready_i,
  output dmi_req_t    dm_req_o,
  output logic        dm_req_valid_o,
  input  logic        dm_req_ready_i,
  input  dmi_resp_t   dm_resp_i,
  input  logic        dm_resp_valid_i,
  output logic        dm_resp_ready_o,
  // halt request
  input  logic        debug_en_i,
  input  logic        halt_req_i,
  output logic        halt_req_o,
  // address decode
  input  logic        req_i,
  input  logic        we_i,
  input  addr_t       addr_i,
  output logic        sel_valid_o,
  output logic        sel_we_o,
  output periph_idx_e sel_idx_o,
  output logic        decerr_o,
  input  logic        clr_i,
  output err_cnt_t    rd_err_cnt_o,
  output err_cnt_t    wr_err_cnt_o,
  // interrupts
  input  logic        meip_i,
  input  logic        seip_i,
  input  logic        mtip_i,
  input  logic        irq_ack_i,
  output irq_vec_t    irq_vec_o,
  output logic        irq_valid_o,
  output irq_id_t     irq_id_o,
  output irq_vec_t    irq_onehot_o
);

  periph_sel_if sel ();

  // ------------------------------------------------------------------------
  // debug
  // ------------------------------------------------------------------------
  dmi_source_mux i_dmi_source_mux (.*);

  debug_req_gate i_debug_req_gate (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .debug_en_i ( debug_en_i ),
    .halt_req_i ( halt_req_i ),
    .halt_req_o ( halt_req_o )
  );

  // ------------------------------------------------------------------------
  // decode and error counting
  // ------------------------------------------------------------------------
  addr_region_decode i_addr_region_decode (
    .clk_i  ( clk_i  ),
    .rst_ni ( rst_ni ),
    .req_i  ( req_i  ),
    .we_i   ( we_i   ),
    .addr_i ( addr_i ),
    .sel    ( sel    )
  );

  access_error_counter i_access_error_counter (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clr_i        ( clr_i        ),
    .sel          ( sel          ),
    .rd_err_cnt_o ( rd_err_cnt_o ),
    .wr_err_cnt_o ( wr_err_cnt_o )
  );

  assign sel_valid_o = sel.valid;
  assign sel_we_o    = sel.write;
  assign sel_idx_o   = sel.idx;
  assign decerr_o    = sel.decerr;

  // ------------------------------------------------------------------------
  // interrupts
  // ------------------------------------------------------------------------
  irq_route i_irq_route (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .meip_i       ( meip_i       ),
    .seip_i       ( seip_i       ),
    .mtip_i       ( mtip_i       ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_vec_o    ( irq_vec_o    ),
    .irq_valid_o  ( irq_valid_o  ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o )
  );

endmodule

`default_nettype wire

// ==== soc_harness.f ====
+incdir+.
logic/harness_pkg.sv
logic/periph_sel_if.sv
logic/dmi_source_mux.sv
logic/debug_req_gate.sv
logic/addr_region_decode.sv
logic/access_error_counter.sv
logic/irq_route.sv
logic/soc_harness_top.sv
verif/tb_soc_harness.sv

// ==== verif/tb_soc_harness.sv ====
/*
  tb_soc_harness
  directed testbench for the soc harness glue: halt request gate,
  address decode, error counters, debug transport mux and interrupt routing
*/
`timescale 1ns/1ps
`default_nettype none

`include "harness_settings.svh"

module tb_soc_harness import harness_pkg::*; ();

  localparam int Timeout = 200;

  // peripheral map in table order, with the index each region must give
  localparam addr_t RegionBase [11] = '{
    `HARNESS_DEBUG_BASE, `HARNESS_ROM_BASE, `HARNESS_CLINT_BASE, `HARNESS_PLIC_BASE,
    `HARNESS_UART_BASE, `HARNESS_TIMER_BASE, `HARNESS_SPI_BASE, `HARNESS_ETH_BASE,
    `HARNESS_GPIO_BASE, `HARNESS_CLIC_BASE, `HARNESS_DRAM_BASE
  };
  localparam addr_t RegionLen [11] = '{
    `HARNESS_DEBUG_LEN, `HARNESS_ROM_LEN, `HARNESS_CLINT_LEN, `HARNESS_PLIC_LEN,
    `HARNESS_UART_LEN, `HARNESS_TIMER_LEN, `HARNESS_SPI_LEN, `HARNESS_ETH_LEN,
    `HARNESS_GPIO_LEN, `HARNESS_CLIC_LEN, `HARNESS_DRAM_LEN
  };
  localparam periph_idx_e RegionIdx [11] = '{
    PERIPH_DEBUG, PERIPH_ROM, PERIPH_CLINT, PERIPH_PLIC, PERIPH_UART, PERIPH_TIMER,
    PERIPH_SPI, PERIPH_ETH, PERIPH_GPIO, PERIPH_CLIC, PERIPH_DRAM
  };

  logic clk_i, rst_ni;
  logic jtag_sel_i, jtag_req_valid_i, jtag_req_ready_o, jtag_resp_valid_o, jtag_resp_ready_i;
  logic dtm_req_valid_i, dtm_req_ready_o, dtm_resp_valid_o, dtm_resp_ready_i;
  logic dm_req_valid_o, dm_req_ready_i, dm_resp_valid_i, dm_resp_ready_o;
  dmi_req_t    jtag_req_i, dtm_req_i, dm_req_o;
  dmi_resp_t   jtag_resp_o, dtm_resp_o, dm_resp_i;
  logic        debug_en_i, halt_req_i, halt_req_o;
  logic        req_i, we_i, sel_valid_o, sel_we_o, decerr_o, clr_i;
  addr_t       addr_i;
  periph_idx_e sel_idx_o;
  err_cnt_t    rd_err_cnt_o, wr_err_cnt_o;
  logic        meip_i, seip_i, mtip_i, irq_ack_i, irq_valid_o;
  irq_vec_t    irq_vec_o, irq_onehot_o;
  irq_id_t     irq_id_o;

  integer seed = 32'h548e;
  int     error_count = 0;
  string  test_name = "init";

  soc_harness_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // failure reporting and typed compares
  // --------------------------------------------------------------------------
  task automatic fail_stop(input string what);
    error_count++;
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_cycles(input string what, input int exp, input int act);
    if (act != exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_idx(input string what, input periph_idx_e exp, input periph_idx_e act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %s, actual %s (%h)",
                          test_name, what, exp.name(), act.name(), act));
    end
  endtask

  task automatic check_cnt(input string what, input err_cnt_t exp, input err_cnt_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_id(input string what, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_vec(input string what, input irq_vec_t exp, input irq_vec_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_req(input string what, input dmi_req_t exp, input dmi_req_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_resp(input string what, input dmi_resp_t exp, input dmi_resp_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error: %s, %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------
  // one access strobe, result checked one cycle later
  task automatic run_access(input addr_t a, input logic w, input periph_idx_e exp_idx,
                            input logic exp_err);
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= w;
    addr_i <= a;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_bit($sformatf("valid for %h", a), 1'b1, sel_valid_o);
    check_bit($sformatf("decerr for %h", a), exp_err, decerr_o);
    check_bit($sformatf("write for %h", a), w, sel_we_o);
    check_idx($sformatf("idx for %h", a), exp_idx, sel_idx_o);
  endtask

  task automatic clear_counts();
    @(posedge clk_i);
    clr_i <= 1'b1;
    @(posedge clk_i);
    clr_i <= 1'b0;
    @(negedge clk_i);
    check_cnt("read count after clear", '0, rd_err_cnt_o);
    check_cnt("write count after clear", '0, wr_err_cnt_o);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic test_gate();
    int n;
    test_name = "gate";
    n = 0;
    @(negedge clk_i);
    while (!halt_req_o) begin
      n++;
      if (n > Timeout) fail_stop("gate: halt request never reached the core");
      @(negedge clk_i);
    end
    check_cycles("hold-off cycles", `HARNESS_DMI_DEL_CYCLES, n);
    @(posedge clk_i);
    halt_req_i <= 1'b0;
    @(negedge clk_i);
    check_bit("halt follows low", 1'b0, halt_req_o);
    @(posedge clk_i);
    halt_req_i <= 1'b1;
    debug_en_i <= 1'b0;
    @(negedge clk_i);
    check_bit("halt with debug disabled", 1'b0, halt_req_o);
    @(posedge clk_i);
    debug_en_i <= 1'b1;
    halt_req_i <= 1'b0;
  endtask

  task automatic test_decode();
    logic [31:0] rnd;
    addr_t       off;
    test_name = "decode";
    for (int i = 0; i < 11; i++) begin
      rnd = $random(seed);
      off = {32'h0, rnd} % RegionLen[i];
      run_access(RegionBase[i], 1'b0, RegionIdx[i], 1'b0);
      run_access(RegionBase[i] + RegionLen[i] - 1, 1'b1, RegionIdx[i], 1'b0);
      run_access(RegionBase[i] + off, rnd[0], RegionIdx[i], 1'b0);
    end
    run_access(`HARNESS_ROM_BASE + `HARNESS_ROM_LEN, 1'b0, PERIPH_DEBUG, 1'b1);
    run_access(64'h6000_0000, 1'b0, PERIPH_DEBUG, 1'b1);
  endtask

  task automatic test_err_count();
    test_name = "error counts";
    clear_counts();
    run_access(64'h6000_0000, 1'b0, PERIPH_DEBUG, 1'b1);
    run_access(64'h0000_1000, 1'b0, PERIPH_DEBUG, 1'b1);
    run_access(`HARNESS_ROM_BASE + `HARNESS_ROM_LEN, 1'b0, PERIPH_DEBUG, 1'b1);
    run_access(64'h6000_0000, 1'b1, PERIPH_DEBUG, 1'b1);
    run_access(64'hF000_0000, 1'b1, PERIPH_DEBUG, 1'b1);
    @(posedge clk_i);
    @(negedge clk_i);
    check_cnt("read count", 16'd3, rd_err_cnt_o);
    check_cnt("write count", 16'd2, wr_err_cnt_o);
    run_access(`HARNESS_UART_BASE, 1'b1, PERIPH_UART, 1'b0);
    @(posedge clk_i);
    @(negedge clk_i);
    check_cnt("read count after mapped access", 16'd3, rd_err_cnt_o);
    check_cnt("write count after mapped access", 16'd2, wr_err_cnt_o);
    clear_counts();
  endtask

  task automatic test_transport();
    dmi_req_t  dtm_req;
    dmi_req_t  jtag_req;
    dmi_resp_t resp;
    dmi_resp_t jtag_resp;
    int        n;
    test_name = "transport";
    dtm_req   = '{addr: 7'h10, op: DTM_READ, data: 32'h0};
    jtag_req  = '{addr: 7'h11, op: DTM_WRITE, data: 32'hcafe_0001};
    resp      = '{data: 32'h1234_5678, resp: 2'b00};
    jtag_resp = '{data: 32'h0bad_f00d, resp: 2'b10};
    @(posedge clk_i);
    dtm_req_i       <= dtm_req;
    dtm_req_valid_i <= 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!dtm_req_ready_o) begin
      n++;
      if (n > Timeout) fail_stop("transport: DTM request never accepted");
      @(negedge clk_i);
    end
    check_req("dtm request at dm port", dtm_req, dm_req_o);
    check_bit("dm request valid", 1'b1, dm_req_valid_o);
    // request transfers here, switch asked for while it is in flight
    @(posedge clk_i);
    dtm_req_valid_i  <= 1'b0;
    jtag_sel_i       <= 1'b1;
    jtag_req_i       <= jtag_req;
    jtag_req_valid_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("jtag ready while dtm outstanding", 1'b0, jtag_req_ready_o);
    check_bit("dm valid while dtm outstanding", 1'b0, dm_req_valid_o);
    // dtm side holds the response off for one cycle
    @(posedge clk_i);
    dm_resp_i        <= resp;
    dm_resp_valid_i  <= 1'b1;
    dtm_resp_ready_i <= 1'b0;
    @(negedge clk_i);
    check_bit("dtm response valid", 1'b1, dtm_resp_valid_o);
    check_bit("jtag response valid", 1'b0, jtag_resp_valid_o);
    check_bit("dm response ready stalled", 1'b0, dm_resp_ready_o);
    check_resp("dtm response", resp, dtm_resp_o);
    @(posedge clk_i);
    dtm_resp_ready_i <= 1'b1;
    @(negedge clk_i);
    check_bit("dm response ready", 1'b1, dm_resp_ready_o);
    check_bit("jtag ready while response stalled", 1'b0, jtag_req_ready_o);
    @(posedge clk_i);
    dm_resp_valid_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!jtag_req_ready_o) begin
      n++;
      if (n > Timeout) fail_stop("transport: select never moved to JTAG");
      @(negedge clk_i);
    end
    check_req("jtag request at dm port", jtag_req, dm_req_o);
    @(posedge clk_i);
    jtag_req_valid_i <= 1'b0;
    @(posedge clk_i);
    dm_resp_i       <= jtag_resp;
    dm_resp_valid_i <= 1'b1;
    @(negedge clk_i);
    check_bit("jtag response valid", 1'b1, jtag_resp_valid_o);
    check_bit("dtm response valid", 1'b0, dtm_resp_valid_o);
    check_resp("jtag response", jtag_resp, jtag_resp_o);
    @(posedge clk_i);
    dm_resp_valid_i <= 1'b0;
  endtask

  task automatic test_irq();
    irq_vec_t exp_vec;
    int       n;
    test_name = "interrupts";
    // meip at 11, mtip at 7
    exp_vec = (irq_vec_t'(1) << 11) | (irq_vec_t'(1) << 7);
    @(posedge clk_i);
    meip_i <= 1'b1;
    mtip_i <= 1'b1;
    @(negedge clk_i);
    check_vec("vector", exp_vec, irq_vec_o);
    for (int k = 0; k < 2; k++) begin
      n = 0;
      while (!irq_valid_o) begin
        n++;
        if (n > Timeout) fail_stop("interrupts: no request presented to the core");
        @(negedge clk_i);
      end
      check_id("request id", (k == 0) ? irq_id_t'(11) : irq_id_t'(7), irq_id_o);
      check_vec("one-hot", irq_vec_t'(1) << ((k == 0) ? 11 : 7), irq_onehot_o);
      @(posedge clk_i);
      irq_ack_i <= 1'b1;
      meip_i    <= 1'b0;
      mtip_i    <= (k == 0);
      @(posedge clk_i);
      irq_ack_i <= 1'b0;
      @(negedge clk_i);
      check_bit("valid after ack", 1'b0, irq_valid_o);
      check_vec("vector after ack", (k == 0) ? irq_vec_t'(1) << 7 : '0, irq_vec_o);
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    jtag_sel_i        = 1'b0;
    jtag_req_i        = '0;
    jtag_req_valid_i  = 1'b0;
    jtag_resp_ready_i = 1'b1;
    dtm_req_i         = '0;
    dtm_req_valid_i   = 1'b0;
    dtm_resp_ready_i  = 1'b1;
    dm_req_ready_i    = 1'b1;
    dm_resp_i         = '0;
    dm_resp_valid_i   = 1'b0;
    debug_en_i        = 1'b1;
    halt_req_i        = 1'b1;
    req_i             = 1'b0;
    we_i              = 1'b0;
    addr_i            = '0;
    clr_i             = 1'b0;
    meip_i            = 1'b0;
    seip_i            = 1'b0;
    mtip_i            = 1'b0;
    irq_ack_i         = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_gate();
    test_decode();
    test_err_count();
    test_transport();
    test_irq();
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
